//--- build.f
+incdir+include
rtl/mem_prep_pkg.sv
rtl/mem_addr_translate.sv
rtl/ll_sc_link.sv
rtl/store_align.sv
rtl/mem_exc_select.sv
rtl/mem_access_prep.sv
verification/mem_access_prep_assertions.sv
verification/mem_access_prep_tb.sv

//--- include/mem_prep_macros.svh
`ifndef MEM_PREP_MACROS_SVH
`define MEM_PREP_MACROS_SVH

// datapath widths
`define MP_ADDR_W 32
`define MP_PFN_W 20
`define MP_OFFSET_W 12

// top three address bits of the unmapped kernel segments
`define MP_SEG_KSEG0 3'b100
`define MP_SEG_KSEG1 3'b101

// cacheable, noncoherent
`define MP_CCA_CACHED 3'b011

`endif

//--- rtl/ll_sc_link.sv
`include "mem_prep_macros.svh"

module ll_sc_link (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`MP_ADDR_W-1:0] vaddr,
    input  logic                  ll,
    input  logic                  sc,
    input  logic                  clear,
    output logic                  sc_ok
);

    logic                  link_valid;
    logic [`MP_ADDR_W-1:0] link_addr;

    // clear wins over a new ll in the same cycle
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            link_valid <= 1'b0;
        end else if (ll) begin
            link_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ll) begin
            link_addr <= vaddr; // only meaningful while link_valid
        end
    end

    assign sc_ok = link_valid && (link_addr == vaddr) && sc;

endmodule

//--- rtl/mem_access_prep.sv
`include "mem_prep_macros.svh"

module mem_access_prep (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`MP_ADDR_W-1:0]       vaddr,
    input  logic [`MP_ADDR_W-1:0]       pc,
    input  logic [`MP_ADDR_W-1:0]       rt_data,
    input  mem_prep_pkg::access_op_t    op,
    input  mem_prep_pkg::tlb_result_t   tlb,
    input  logic [2:0]                  k0_cca,
    input  logic                        interrupt,
    input  logic                        overflow,
    input  logic                        trap,
    input  logic                        eret_flush,
    input  mem_prep_pkg::prior_exc_t    prior,
    output logic [`MP_ADDR_W-1:0]       paddr,
    output logic                        uncached,
    output logic                        dcache_valid,
    output logic                        uncache_valid,
    output logic                        dm_en,
    output mem_prep_pkg::store_req_t    store,
    output mem_prep_pkg::exc_info_t     exc,
    output logic [`MP_ADDR_W-1:0]       sc_result,
    output logic                        invalid
);

    import mem_prep_pkg::*;

    tlb_exc_t tlb_exc;
    logic     sc_ok;
    logic     sc_permit;
    logic     write_en;
    logic     link_clear;

    // a failed sc turns into a no-op
    assign sc_permit = !op.sc || sc_ok;
    assign write_en  = op.wr && sc_permit;

    mem_addr_translate translate_i (
        .vaddr       (vaddr),
        .active      (op.en),
        .write       (write_en),
        .tlb         (tlb),
        .k0_cca      (k0_cca),
        .prior_valid (prior.valid),
        .paddr       (paddr),
        .uncached    (uncached),
        .tlb_exc     (tlb_exc)
    );

    assign link_clear = eret_flush || exc.exception;

    ll_sc_link link_i (
        .clk   (clk),
        .reset (reset),
        .vaddr (vaddr),
        .ll    (op.ll),
        .sc    (op.sc),
        .clear (link_clear),
        .sc_ok (sc_ok)
    );

    store_align align_i (
        .write    (write_en),
        .size     (op.size),
        .kind     (op.kind),
        .byte_sel (paddr[1:0]),
        .rt_data  (rt_data),
        .store    (store)
    );

    mem_exc_select exc_sel_i (
        .op        (op),
        .vaddr     (vaddr),
        .pc        (pc),
        .interrupt (interrupt),
        .overflow  (overflow),
        .trap      (trap),
        .prior     (prior),
        .tlb_exc   (tlb_exc),
        .exc       (exc)
    );

    assign dcache_valid  = op.en && !uncached && sc_permit;
    assign uncache_valid = op.en && uncached && sc_permit;
    assign dm_en         = op.en && !exc.exception && !eret_flush && sc_permit;
    assign invalid       = exc.exception || eret_flush;

    // sc writes its success flag back to rt
    assign sc_result = {{(`MP_ADDR_W-1){1'b0}}, dcache_valid || uncache_valid};

endmodule

//--- rtl/mem_addr_translate.sv
`include "mem_prep_macros.svh"

module mem_addr_translate (
    input  logic [`MP_ADDR_W-1:0]   vaddr,
    input  logic                    active,
    input  logic                    write,
    input  mem_prep_pkg::tlb_result_t tlb,
    input  logic [2:0]              k0_cca,
    input  logic                    prior_valid,
    output logic [`MP_ADDR_W-1:0]   paddr,
    output logic                    uncached,
    output mem_prep_pkg::tlb_exc_t  tlb_exc
);

    logic kseg0;
    logic kseg1;
    logic seg_mapped;
    logic mapped;
    logic tlb_check;
    logic tlb_miss_or_inv;
    logic cached;

    assign kseg0 = (vaddr[`MP_ADDR_W-1 -: 3] == `MP_SEG_KSEG0);
    assign kseg1 = (vaddr[`MP_ADDR_W-1 -: 3] == `MP_SEG_KSEG1);

    // useg and kseg2/3 go through the tlb
    assign seg_mapped = !kseg0 && !kseg1;
    assign mapped     = active && seg_mapped;

    always_comb begin
        if (mapped) begin
            paddr = {tlb.pfn, vaddr[`MP_OFFSET_W-1:0]};
        end else begin
            paddr = {3'b000, vaddr[`MP_ADDR_W-4:0]};
        end
    end

    assign cached = (kseg0 && (k0_cca == `MP_CCA_CACHED))
                 || (seg_mapped && (tlb.cca == `MP_CCA_CACHED));
    assign uncached = !cached;

    // an earlier exception masks the lookup result
    assign tlb_check       = mapped && !prior_valid;
    assign tlb_miss_or_inv = !tlb.found || !tlb.valid;

    assign tlb_exc.refill = tlb_check && !tlb.found;
    assign tlb_exc.tlbl   = tlb_check && !write && tlb_miss_or_inv;
    assign tlb_exc.tlbs   = tlb_check && write && tlb_miss_or_inv;
    assign tlb_exc.tlbmod = tlb_check && write && tlb.found && tlb.valid && !tlb.dirty;

endmodule

//--- rtl/mem_exc_select.sv
`include "mem_prep_macros.svh"

module mem_exc_select (
    input  mem_prep_pkg::access_op_t op,
    input  logic [`MP_ADDR_W-1:0]    vaddr,
    input  logic [`MP_ADDR_W-1:0]    pc,
    input  logic                     interrupt,
    input  logic                     overflow,
    input  logic                     trap,
    input  mem_prep_pkg::prior_exc_t prior,
    input  mem_prep_pkg::tlb_exc_t   tlb_exc,
    output mem_prep_pkg::exc_info_t  exc
);

    import mem_prep_pkg::*;

    logic      misaligned;
    logic      plain;
    logic      ades;
    logic      adel;
    logic      tlb_any;
    exc_code_e tlb_code;

    // lwl/lwr/swl/swr never fault on alignment
    assign plain = (op.kind == KIND_PLAIN);

    assign misaligned = ((op.size == SIZE_HALF) && vaddr[0])
                     || ((op.size == SIZE_WORD) && (vaddr[1:0] != 2'b00));

    assign ades = op.wr && plain && misaligned;
    assign adel = op.rd && plain && misaligned;

    assign tlb_any = tlb_exc.tlbl || tlb_exc.tlbs || tlb_exc.tlbmod;

    always_comb begin
        if (tlb_exc.tlbl) begin
            tlb_code = EXC_TLBL;
        end else if (tlb_exc.tlbs) begin
            tlb_code = EXC_TLBS;
        end else if (tlb_exc.tlbmod) begin
            tlb_code = EXC_MOD;
        end else begin
            tlb_code = EXC_INT;
        end
    end

    assign exc.exception = interrupt || prior.valid || overflow || trap
                        || ades || adel || tlb_any;

    always_comb begin
        if (interrupt) begin
            exc.code     = EXC_INT;
            exc.badvaddr = '0;
        end else if (prior.valid) begin
            exc.code     = prior.code;
            exc.badvaddr = pc; // earlier faults report the instruction address
        end else if (overflow) begin
            exc.code     = EXC_OV;
            exc.badvaddr = '0;
        end else if (trap) begin
            exc.code     = EXC_TR;
            exc.badvaddr = '0;
        end else if (ades) begin
            exc.code     = EXC_ADES;
            exc.badvaddr = vaddr;
        end else if (adel) begin
            exc.code     = EXC_ADEL;
            exc.badvaddr = vaddr;
        end else begin
            exc.code     = tlb_code;
            exc.badvaddr = vaddr;
        end
    end

    assign exc.tlb_refill = tlb_exc.refill || prior.tlb_refill;
    assign exc.tlb        = tlb_any || prior.tlb;

endmodule

//--- rtl/mem_prep_pkg.sv
`include "mem_prep_macros.svh"

package mem_prep_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // plain, swl/lwl, swr/lwr
    typedef enum logic [1:0] {
        KIND_PLAIN = 2'd0,
        KIND_LEFT  = 2'd1,
        KIND_RIGHT = 2'd2
    } access_kind_e;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_OV   = 5'd12,
        EXC_TR   = 5'd13
    } exc_code_e;

    typedef struct packed {
        logic         en;   // load or store in this stage
        logic         wr;
        logic         rd;
        mem_size_e    size;
        access_kind_e kind;
        logic         ll;
        logic         sc;
    } access_op_t;

    typedef struct packed {
        logic                 found;
        logic                 valid;
        logic                 dirty;
        logic [`MP_PFN_W-1:0] pfn;
        logic [2:0]           cca;
    } tlb_result_t;

    typedef struct packed {
        logic refill;
        logic tlbl;
        logic tlbs;
        logic tlbmod;
    } tlb_exc_t;

    // raised before the memory stage
    typedef struct packed {
        logic      valid;
        exc_code_e code;
        logic      tlb_refill;
        logic      tlb;
    } prior_exc_t;

    typedef struct packed {
        logic                  exception;
        exc_code_e             code;
        logic [`MP_ADDR_W-1:0] badvaddr;
        logic                  tlb_refill;
        logic                  tlb;
    } exc_info_t;

    typedef struct packed {
        logic [3:0]            wstrb;
        logic [`MP_ADDR_W-1:0] wdata;
    } store_req_t;

endpackage

//--- rtl/store_align.sv
`include "mem_prep_macros.svh"

module store_align (
    input  logic                       write,
    input  mem_prep_pkg::mem_size_e    size,
    input  mem_prep_pkg::access_kind_e kind,
    input  logic [1:0]                 byte_sel,
    input  logic [`MP_ADDR_W-1:0]      rt_data,
    output mem_prep_pkg::store_req_t   store
);

    import mem_prep_pkg::*;

    logic [3:0] strb;

    always_comb begin
        strb = 4'b0000;
        if (write) begin
            case (kind)
                KIND_LEFT: begin
                    case (byte_sel)
                        2'b00:   strb = 4'b0001;
                        2'b01:   strb = 4'b0011;
                        2'b10:   strb = 4'b0111;
                        default: strb = 4'b1111;
                    endcase
                end
                KIND_RIGHT: begin
                    case (byte_sel)
                        2'b00:   strb = 4'b1111;
                        2'b01:   strb = 4'b1110;
                        2'b10:   strb = 4'b1100;
                        default: strb = 4'b1000;
                    endcase
                end
                default: begin
                    case (size)
                        SIZE_BYTE: strb = 4'b0001 << byte_sel;
                        SIZE_HALF: strb = byte_sel[1] ? 4'b1100 : 4'b0011;
                        default:   strb = 4'b1111;
                    endcase
                end
            endcase
        end
    end

    // partial word stores move the register bytes onto their lanes
    always_comb begin
        store.wdata = rt_data;
        if (kind == KIND_LEFT) begin
            case (strb)
                4'b0001: store.wdata = {4{rt_data[31:24]}};
                4'b0011: store.wdata = {2{rt_data[31:16]}};
                4'b0111: store.wdata = {8'b0, rt_data[31:8]};
                default: store.wdata = rt_data;
            endcase
        end else if (kind == KIND_RIGHT) begin
            case (strb)
                4'b1000: store.wdata = {4{rt_data[7:0]}};
                4'b1100: store.wdata = {2{rt_data[15:0]}};
                4'b1110: store.wdata = {rt_data[23:0], 8'b0};
                default: store.wdata = rt_data;
            endcase
        end
    end

    assign store.wstrb = strb;

endmodule

//--- run.sh
#!/bin/sh
# compile and run the memory access prep testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module mem_access_prep_tb
if [ $? -ne 0 ]; then
    echo "compilation failed"
    exit 1
fi

out=$(./obj_dir/Vmem_access_prep_tb +verilator+error+limit+100 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Everything OK"; then
    exit 0
fi
exit 1

//--- verification/mem_access_cases.txt
# in: vaddr pc rt_data op tlb_fvd pfn cca k0_cca irq_ov_tr_eret prior_v prior_code prior_flags
# out: paddr unc_dc_unc_dm invalid wstrb wdata exception code badvaddr refill_tlb sc_result
80001000 bfc00100 11223344 1a1 7 12345 3 3 0 0 00 0  00001000 0 0 0 11223344 0 00 80001000 0 0
80001000 bfc00100 11223344 162 7 12345 3 3 0 0 00 0  00001000 5 0 0 11223344 0 00 80001000 0 1
80001000 bfc00100 11223344 1a1 7 12345 3 3 0 0 00 0  00001000 5 0 f 11223344 0 00 80001000 0 1
80001004 bfc00100 11223344 1a1 7 12345 3 3 0 0 00 0  00001004 0 0 0 11223344 0 00 80001004 0 0
80002000 bfc00100 11223344 162 7 12345 3 3 0 0 00 0  00002000 5 0 0 11223344 0 00 80002000 0 1
80002000 bfc00100 11223344 000 7 12345 3 3 1 0 00 0  00002000 0 1 0 11223344 0 00 80002000 0 0
80002000 bfc00100 11223344 1a1 7 12345 3 3 0 0 00 0  00002000 0 0 0 11223344 0 00 80002000 0 0
80003000 bfc00100 11223344 162 7 12345 3 3 0 0 00 0  00003000 5 0 0 11223344 0 00 80003000 0 1
80003001 bfc00100 11223344 160 7 12345 3 3 0 0 00 0  00003001 4 1 0 11223344 1 04 80003001 0 1
80003000 bfc00100 11223344 1a1 7 12345 3 3 0 0 00 0  00003000 0 0 0 11223344 0 00 80003000 0 0
80004002 bfc00100 11223344 1a0 7 12345 3 3 e 1 02 0  00004002 4 1 f 11223344 1 00 00000000 0 1
80004002 bfc00100 11223344 1a0 7 12345 3 3 6 1 0d 3  00004002 4 1 f 11223344 1 0d bfc00100 3 1
80004002 bfc00100 11223344 1a0 7 12345 3 3 6 0 00 0  00004002 4 1 f 11223344 1 0c 00000000 0 1
80004002 bfc00100 11223344 1a0 7 12345 3 3 2 0 00 0  00004002 4 1 f 11223344 1 0d 00000000 0 1
80004002 bfc00100 11223344 1a0 7 12345 3 3 0 0 00 0  00004002 4 1 f 11223344 1 05 80004002 0 1
a0005008 bfc00100 11223344 160 7 12345 3 3 0 0 00 0  00005008 b 0 0 11223344 0 00 a0005008 0 1
00403010 bfc00100 11223344 160 7 12345 3 3 0 0 00 0  12345010 5 0 0 11223344 0 00 00403010 0 1
c0001234 bfc00100 11223344 160 7 abcde 2 3 0 0 00 0  abcde234 b 0 0 11223344 0 00 c0001234 0 1
80006000 bfc00100 11223344 160 7 12345 3 2 0 0 00 0  00006000 b 0 0 11223344 0 00 80006000 0 1
00407000 bfc00100 11223344 160 0 00111 3 3 0 0 00 0  00111000 4 1 0 11223344 1 02 00407000 3 1
00408000 bfc00100 11223344 1a0 5 00222 3 3 0 0 00 0  00222000 4 1 f 11223344 1 03 00408000 1 1
00409004 bfc00100 11223344 1a0 6 00333 3 3 0 0 00 0  00333004 4 1 f 11223344 1 01 00409004 1 1
0040b000 bfc00100 11223344 160 5 00555 3 3 0 0 00 0  00555000 4 1 0 11223344 1 02 0040b000 1 1
0040a000 bfc00100 11223344 160 0 00444 3 3 0 1 02 0  00444000 4 1 0 11223344 1 02 bfc00100 0 1
80007000 bfc00100 11223344 180 7 12345 3 3 0 0 00 0  00007000 5 0 1 11223344 0 00 80007000 0 1
80007001 bfc00100 11223344 180 7 12345 3 3 0 0 00 0  00007001 5 0 2 11223344 0 00 80007001 0 1
80007002 bfc00100 11223344 180 7 12345 3 3 0 0 00 0  00007002 5 0 4 11223344 0 00 80007002 0 1
80007003 bfc00100 11223344 180 7 12345 3 3 0 0 00 0  00007003 5 0 8 11223344 0 00 80007003 0 1
80007000 bfc00100 11223344 190 7 12345 3 3 0 0 00 0  00007000 5 0 3 11223344 0 00 80007000 0 1
80007002 bfc00100 11223344 190 7 12345 3 3 0 0 00 0  00007002 5 0 c 11223344 0 00 80007002 0 1
80007000 bfc00100 11223344 1a4 7 12345 3 3 0 0 00 0  00007000 5 0 1 11111111 0 00 80007000 0 1
80007001 bfc00100 11223344 1a4 7 12345 3 3 0 0 00 0  00007001 5 0 3 11221122 0 00 80007001 0 1
80007002 bfc00100 11223344 1a4 7 12345 3 3 0 0 00 0  00007002 5 0 7 00112233 0 00 80007002 0 1
80007003 bfc00100 11223344 1a4 7 12345 3 3 0 0 00 0  00007003 5 0 f 11223344 0 00 80007003 0 1
80007000 bfc00100 11223344 1a8 7 12345 3 3 0 0 00 0  00007000 5 0 f 11223344 0 00 80007000 0 1
80007001 bfc00100 11223344 1a8 7 12345 3 3 0 0 00 0  00007001 5 0 e 22334400 0 00 80007001 0 1
80007002 bfc00100 11223344 1a8 7 12345 3 3 0 0 00 0  00007002 5 0 c 33443344 0 00 80007002 0 1
80007003 bfc00100 11223344 1a8 7 12345 3 3 0 0 00 0  00007003 5 0 8 44444444 0 00 80007003 0 1

//--- verification/mem_access_prep_assertions.sv
module mem_access_prep_assertions (
    input logic                      clk,
    input logic                      reset,
    input mem_prep_pkg::access_op_t  op,
    input logic                      dcache_valid,
    input logic                      uncache_valid,
    input logic                      dm_en,
    input mem_prep_pkg::store_req_t  store,
    input mem_prep_pkg::exc_info_t   exc
);

    int violations = 0;

    one_path_a: assert property (@(posedge clk) disable iff (reset)
        !(dcache_valid && uncache_valid))
    else begin
        violations++;
        $error("cached and uncached requests valid together");
    end

    // loads never write
    no_strobe_a: assert property (@(posedge clk) disable iff (reset)
        !op.wr |-> (store.wstrb == 4'b0000))
    else begin
        violations++;
        $error("byte strobes set without a store");
    end

    exc_blocks_mem_a: assert property (@(posedge clk) disable iff (reset)
        exc.exception |-> !dm_en)
    else begin
        violations++;
        $error("memory enable high while an exception is taken");
    end

endmodule

bind mem_access_prep mem_access_prep_assertions assert_i (
    .clk           (clk),
    .reset         (reset),
    .op            (op),
    .dcache_valid  (dcache_valid),
    .uncache_valid (uncache_valid),
    .dm_en         (dm_en),
    .store         (store),
    .exc           (exc)
);

//--- verification/mem_access_prep_tb.sv
`include "mem_prep_macros.svh"

module mem_access_prep_tb;

    import mem_prep_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DELAY  = 2;
    localparam int FIELDS       = 22;

    typedef struct packed {
        logic [`MP_ADDR_W-1:0] vaddr;
        logic [`MP_ADDR_W-1:0] pc;
        logic [`MP_ADDR_W-1:0] rt;
        access_op_t            op;
        tlb_result_t           tlb;
        logic [2:0]            k0;
        logic [3:0]            flags;   // interrupt, overflow, trap, eret_flush
        prior_exc_t            prior;
        logic [`MP_ADDR_W-1:0] paddr;
        logic [3:0]            enables; // uncached, dcache, uncache, dm_en
        logic                  invalid;
        store_req_t            store;
        exc_info_t             exc;
        logic                  sc;
    } case_t;

    logic                  clk;
    logic                  reset;
    logic [`MP_ADDR_W-1:0] vaddr;
    logic [`MP_ADDR_W-1:0] pc;
    logic [`MP_ADDR_W-1:0] rt_data;
    access_op_t            op;
    tlb_result_t           tlb;
    logic [2:0]            k0_cca;
    logic                  interrupt;
    logic                  overflow;
    logic                  trap;
    logic                  eret_flush;
    prior_exc_t            prior;
    logic [`MP_ADDR_W-1:0] paddr;
    logic                  uncached;
    logic                  dcache_valid;
    logic                  uncache_valid;
    logic                  dm_en;
    store_req_t            store;
    exc_info_t             exc;
    logic [`MP_ADDR_W-1:0] sc_result;
    logic                  invalid;

    case_t cases[$];
    int    num_cases = 0;
    int    case_idx = 0;

    mem_access_prep dut_i (
        .clk           (clk),
        .reset         (reset),
        .vaddr         (vaddr),
        .pc            (pc),
        .rt_data       (rt_data),
        .op            (op),
        .tlb           (tlb),
        .k0_cca        (k0_cca),
        .interrupt     (interrupt),
        .overflow      (overflow),
        .trap          (trap),
        .eret_flush    (eret_flush),
        .prior         (prior),
        .paddr         (paddr),
        .uncached      (uncached),
        .dcache_valid  (dcache_valid),
        .uncache_valid (uncache_valid),
        .dm_en         (dm_en),
        .store         (store),
        .exc           (exc),
        .sc_result     (sc_result),
        .invalid       (invalid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [FIELDS];
        case_t       c;
        fd = $fopen("verification/mem_access_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file verification/mem_access_cases.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 8 || line.getc(0) == "#") begin
                continue; // blank or column notes
            end
            n = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
                        f[18], f[19], f[20], f[21]);
            if (n != FIELDS) begin
                $display("malformed line in the case file: %s", line);
                abort_run();
            end
            c.vaddr   = f[0];
            c.pc      = f[1];
            c.rt      = f[2];
            c.op      = access_op_t'(f[3][8:0]);
            c.tlb     = tlb_result_t'({f[4][2:0], f[5][19:0], f[6][2:0]});
            c.k0      = f[7][2:0];
            c.flags   = f[8][3:0];
            c.prior   = prior_exc_t'({f[9][0], f[10][4:0], f[11][1:0]});
            c.paddr   = f[12];
            c.enables = f[13][3:0];
            c.invalid = f[14][0];
            c.store   = store_req_t'({f[15][3:0], f[16]});
            c.exc     = exc_info_t'({f[17][0], f[18][4:0], f[19], f[20][1:0]});
            c.sc      = f[21][0];
            cases.push_back(c);
        end
        $fclose(fd);
        num_cases = cases.size();
    endtask

    task automatic drive_case(input case_t c);
        vaddr   = c.vaddr;
        pc      = c.pc;
        rt_data = c.rt;
        op      = c.op;
        tlb     = c.tlb;
        k0_cca  = c.k0;
        {interrupt, overflow, trap, eret_flush} = c.flags;
        prior   = c.prior;
    endtask

    task automatic word_compare(input string name, input logic [`MP_ADDR_W-1:0] exp_v,
                                input logic [`MP_ADDR_W-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("ERR case %0d %s: expected %h, got %h", case_idx, name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic flag_compare(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("ERR case %0d %s: expected %h, got %h", case_idx, name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic store_compare(input store_req_t exp_v, input store_req_t act_v);
        if (act_v !== exp_v) begin
            $display("ERR case %0d store: expected wstrb %h wdata %h, got wstrb %h wdata %h",
                     case_idx, exp_v.wstrb, exp_v.wdata, act_v.wstrb, act_v.wdata);
            abort_run();
        end
    endtask

    task automatic exc_compare(input exc_info_t exp_v, input exc_info_t act_v);
        logic bad;
        bad = (act_v.exception !== exp_v.exception)
           || (act_v.tlb_refill !== exp_v.tlb_refill)
           || (act_v.tlb !== exp_v.tlb);
        // code and badvaddr only mean something when an exception is taken
        if (exp_v.exception) begin
            bad = bad || (act_v.code !== exp_v.code) || (act_v.badvaddr !== exp_v.badvaddr);
        end
        if (bad) begin
            $display("ERR case %0d exc: expected %h, got %h", case_idx, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic compare_outputs(input case_t c);
        word_compare("paddr", c.paddr, paddr);
        flag_compare("uncached", c.enables[3], uncached);
        flag_compare("dcache_valid", c.enables[2], dcache_valid);
        flag_compare("uncache_valid", c.enables[1], uncache_valid);
        flag_compare("dm_en", c.enables[0], dm_en);
        flag_compare("invalid", c.invalid, invalid);
        store_compare(c.store, store);
        exc_compare(c.exc, exc);
        word_compare("sc_result", {{(`MP_ADDR_W-1){1'b0}}, c.sc}, sc_result);
    endtask

    initial begin
        wait (num_cases > 0);
        #((num_cases + 10) * CLK_PERIOD);
        $display("timeout: the case sequence did not finish in time");
        abort_run();
    end

    initial begin
        reset      = 1'b1;
        vaddr      = '0;
        pc         = '0;
        rt_data    = '0;
        op         = '0;
        tlb        = '0;
        k0_cca     = 3'b000;
        interrupt  = 1'b0;
        overflow   = 1'b0;
        trap       = 1'b0;
        eret_flush = 1'b0;
        prior      = '0;
        load_cases();
        if (num_cases == 0) begin
            $display("the case file holds no cases");
            abort_run();
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        for (case_idx = 0; case_idx < num_cases; case_idx++) begin
            drive_case(cases[case_idx]);
            #(CLK_PERIOD - 2 * DRIVE_DELAY); // sample just before the next edge
            compare_outputs(cases[case_idx]);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        if (dut_i.assert_i.violations == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d assertion violations were seen", dut_i.assert_i.violations);
            abort_run();
        end
    end

endmodule
